// File: source/capture_pkg.sv
// shared widths, sample types and beat structs for the capture buffer
// imported by every capture and readout block

package capture_pkg;

  // lane count and sample width are fixed here since the structs depend on them
  localparam int LANES = 4;
  localparam int SAMPLE_WIDTH = 16;

  // one sample and a full row of lanes
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [LANES-1:0][SAMPLE_WIDTH-1:0] lane_bus_t;

  // active lane count, 0 to LANES inclusive
  typedef logic [$clog2(LANES+1)-1:0] lane_count_t;

  // one bit per bank, and a bank number
  typedef logic [LANES-1:0] bank_mask_t;
  typedef logic [$clog2(LANES)-1:0] bank_index_t;

  // input beat, one valid frames all lanes
  typedef struct packed {
    logic valid;
    lane_bus_t data;
  } capture_in_t;

  // latched at the start of a capture
  // full_mask marks the last group of banks, init_mask the first group
  typedef struct packed {
    lane_count_t lane_count;
    bank_mask_t full_mask;
    bank_mask_t init_mask;
  } capture_mode_t;

  // readout payload
  typedef struct packed {
    sample_t data;
    logic last;
  } stream_beat_t;

endpackage

// File: source/latency_pipe.sv
// stall-able delay line for any payload type
// valid bits reset, payload stages do not

`timescale 1ns/1ps
module latency_pipe #(
  parameter int DEPTH = 2,
  parameter type payload_t = logic
) (
  input logic capture_clk,
  input logic capture_reset,
  input logic advance,
  input logic in_valid,
  input payload_t in_payload,
  output logic out_valid,
  output payload_t out_payload
);

  logic [DEPTH-1:0] valid_q;
  payload_t payload_q [DEPTH];

  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge capture_clk) begin
    if (advance) begin
      payload_q[0] <= in_payload;
      for (int i = 1; i < DEPTH; i++) begin
        payload_q[i] <= payload_q[i-1];
      end
    end
  end

  assign out_valid = valid_q[DEPTH-1];
  assign out_payload = payload_q[DEPTH-1];

endmodule

// File: source/capture_control.sv
// capture FSM: start/stop edge detection, lane mode latching and the active flag
// the mode and start pulse feed the router and the bank write counter

`timescale 1ns/1ps
module capture_control import capture_pkg::*; (
  input logic capture_clk,
  input logic capture_reset,
  input logic start,
  input logic stop,
  input logic sw_reset,
  input logic group_full_now,
  input lane_count_t active_channels,
  output capture_mode_t capture_mode,
  output logic start_edge,
  output logic active
);

  typedef enum logic {
    IDLE,
    CAPTURING
  } state_t;

  state_t state;
  logic start_q;
  logic stop_q;
  logic stop_edge;
  capture_mode_t mode_next;

  //////////////////////////////////////////////////
  // edge detection
  //////////////////////////////////////////////////

  // edge pulses are registered, so capture goes active two cycles after start
  // a start while capturing is ignored and does not touch the mode
  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      start_q <= 1'b0;
      stop_q <= 1'b0;
      start_edge <= 1'b0;
      stop_edge <= 1'b0;
    end else begin
      start_q <= start;
      stop_q <= stop;
      start_edge <= start & ~start_q & (state == IDLE);
      stop_edge <= stop & ~stop_q;
    end
  end

  //////////////////////////////////////////////////
  // lane mode
  //////////////////////////////////////////////////

  // first group = low banks, last group = high banks
  // e.g. 2 lanes gives init 0011 and full 1100
  always_comb begin
    mode_next.lane_count = active_channels;
    for (int b = 0; b < LANES; b++) begin
      mode_next.init_mask[b] = b < int'(active_channels);
      mode_next.full_mask[b] = b >= LANES - int'(active_channels);
    end
  end

  // latched one cycle before the state change, so it is stable once active
  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      capture_mode <= '0;
    end else if (start & ~start_q & (state == IDLE)) begin
      capture_mode <= mode_next;
    end
  end

  //////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (capture_reset | sw_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (start_edge) begin
            state <= CAPTURING;
          end
        end
        CAPTURING: begin
          // stop edge, or the last group just took its final word
          if (stop_edge | group_full_now) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign active = (state == CAPTURING);

endmodule

// File: source/bank_write_counter.sv
// per-bank write pointers, full latches and bank chaining for the capture buffer
// reports write depth per bank and the overall full flag

`timescale 1ns/1ps
module bank_write_counter import capture_pkg::*; #(
  parameter int BUFFER_DEPTH = 16
) (
  input logic capture_clk,
  input logic capture_reset,
  input logic sw_reset,
  input logic readout_done,
  input capture_mode_t capture_mode,
  input logic start_edge,
  input bank_mask_t write_enable,
  output logic [LANES-1:0][$clog2(BUFFER_DEPTH)-1:0] write_addr,
  output bank_mask_t write_mask,
  output logic group_full_now,
  output logic full,
  output logic [LANES-1:0][$clog2(BUFFER_DEPTH+1)-1:0] write_depth
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int DEPTH_WIDTH = $clog2(BUFFER_DEPTH+1);

  bank_mask_t last_write;
  bank_mask_t bank_full;
  bank_mask_t mask_next;

  // write to the final address of a bank
  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      last_write[b] = write_enable[b] & (write_addr[b] == ADDR_WIDTH'(BUFFER_DEPTH - 1));
    end
  end

  // capture ends the cycle a last-group bank takes its final word
  assign group_full_now = |(last_write & capture_mode.full_mask);

  //////////////////////////////////////////////////
  // pointers and full latches
  //////////////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (capture_reset | sw_reset | readout_done) begin
      write_addr <= '0;
      bank_full <= '0;
    end else begin
      for (int b = 0; b < LANES; b++) begin
        if (last_write[b]) begin
          write_addr[b] <= '0;
          bank_full[b] <= 1'b1;
        end else if (write_enable[b]) begin
          write_addr[b] <= write_addr[b] + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // bank hand-over
  //////////////////////////////////////////////////

  // a filled bank drops out and the bank lane_count above it takes over
  // the chain ends at the top bank, so the last group has no successor
  always_comb begin
    mask_next = write_mask;
    for (int b = 0; b < LANES; b++) begin
      if (last_write[b]) begin
        mask_next[b] = 1'b0;
        if (b + int'(capture_mode.lane_count) < LANES) begin
          mask_next[b + int'(capture_mode.lane_count)] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge capture_clk) begin
    if (capture_reset | sw_reset) begin
      write_mask <= '0;
    end else if (start_edge) begin
      write_mask <= capture_mode.init_mask;
    end else begin
      write_mask <= mask_next;
    end
  end

  //////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////

  // a full bank has a wrapped pointer, so report the depth itself
  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      write_depth <= '0;
    end else begin
      for (int b = 0; b < LANES; b++) begin
        if (bank_full[b]) begin
          write_depth[b] <= DEPTH_WIDTH'(BUFFER_DEPTH);
        end else begin
          write_depth[b] <= DEPTH_WIDTH'(write_addr[b]);
        end
      end
    end
  end

  // only banks in the last group count toward full
  assign full = |(bank_full & capture_mode.full_mask);

endmodule

// File: source/bank_router.sv
// input register stage and lane-to-bank routing
// bank b takes lane (b mod lane count) and writes two edges after the beat arrives

`timescale 1ns/1ps
module bank_router import capture_pkg::*; #(
  parameter int BUFFER_DEPTH = 16
) (
  input logic capture_clk,
  input capture_in_t capture_in,
  input capture_mode_t capture_mode,
  input logic active,
  input bank_mask_t write_mask,
  input logic [LANES-1:0][$clog2(BUFFER_DEPTH)-1:0] write_addr,
  output bank_mask_t write_enable,
  output bank_mask_t bank_write,
  output logic [LANES-1:0][$clog2(BUFFER_DEPTH)-1:0] bank_addr,
  output lane_bus_t bank_data
);

  capture_in_t capture_q;
  bank_index_t lane_wrap;
  lane_bus_t routed;

  // first stage, raw beat
  always_ff @(posedge capture_clk) begin
    capture_q <= capture_in;
  end

  // lane counts are powers of two, so the modulo is a mask
  assign lane_wrap = bank_index_t'(capture_mode.lane_count - 1'b1);

  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      routed[b] = capture_q.data[bank_index_t'(b) & lane_wrap];
    end
  end

  // one valid for every lane
  // the counter steps on these in the same cycle
  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      write_enable[b] = capture_q.valid & active & write_mask[b];
    end
  end

  // second stage
  // address is the counter value before it steps, so it lines up with the data
  always_ff @(posedge capture_clk) begin
    bank_write <= write_enable;
    bank_data <= routed;
    bank_addr <= write_addr;
  end

endmodule

// File: source/sample_banks.sv
// sample storage, one array per bank with its own write port
// all banks read one shared address, the output mux picks a bank

`timescale 1ns/1ps
module sample_banks import capture_pkg::*; #(
  parameter int BUFFER_DEPTH = 16
) (
  input logic capture_clk,
  input bank_mask_t bank_write,
  input logic [LANES-1:0][$clog2(BUFFER_DEPTH)-1:0] bank_addr,
  input lane_bus_t bank_data,
  input bank_index_t read_bank,
  input logic [$clog2(BUFFER_DEPTH)-1:0] read_addr,
  input logic read_enable,
  output sample_t read_data
);

  lane_bus_t bank_rd;

  for (genvar b = 0; b < LANES; b++) begin : g_bank
    sample_t mem [BUFFER_DEPTH];
    sample_t rd_q;

    always_ff @(posedge capture_clk) begin
      if (bank_write[b]) begin
        mem[bank_addr[b]] <= bank_data[b];
      end
    end

    // read register holds under back-pressure
    always_ff @(posedge capture_clk) begin
      if (read_enable) begin
        rd_q <= mem[read_addr];
      end
    end

    assign bank_rd[b] = rd_q;
  end

  // read_bank arrives delayed to match the read register
  assign read_data = bank_rd[read_bank];

endmodule

// File: source/readout_sequencer.sv
// readout walker: steps address then bank, carries sideband and data to the stream
// the whole pipe stalls under back-pressure, done is the transfer of the last beat

`timescale 1ns/1ps
module readout_sequencer import capture_pkg::*; #(
  parameter int BUFFER_DEPTH = 16,
  parameter int READ_LATENCY = 3
) (
  input logic capture_clk,
  input logic capture_reset,
  input logic sw_reset,
  input logic readout_start,
  output bank_index_t read_bank,
  output logic [$clog2(BUFFER_DEPTH)-1:0] read_addr,
  output logic read_enable,
  input sample_t read_data,
  output stream_beat_t readout_out,
  output logic readout_valid,
  input logic readout_ready,
  output logic readout_done
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);

  // bank and last ride along with the storage read register
  typedef struct packed {
    bank_index_t bank;
    logic last;
  } read_side_t;

  logic start_q;
  logic walking;
  logic advance;
  logic flush;
  logic issue_last;
  bank_index_t walk_bank;
  read_side_t side_in;
  read_side_t side_out;
  logic side_valid;
  stream_beat_t beat_in;
  stream_beat_t beat_out;
  logic beat_valid;

  // move on when the output register is empty or being drained
  assign advance = readout_ready | ~readout_valid;
  assign flush = capture_reset | sw_reset;
  assign read_enable = advance;

  //////////////////////////////////////////////////
  // address and bank walker
  //////////////////////////////////////////////////

  assign issue_last = (read_addr == ADDR_WIDTH'(BUFFER_DEPTH - 1)) &
                      (walk_bank == bank_index_t'(LANES - 1));

  always_ff @(posedge capture_clk) begin
    if (flush) begin
      start_q <= 1'b0;
      walking <= 1'b0;
      read_addr <= '0;
      walk_bank <= '0;
    end else begin
      start_q <= readout_start;
      if (readout_start & ~start_q) begin
        // a new edge always restarts from bank 0
        walking <= 1'b1;
        read_addr <= '0;
        walk_bank <= '0;
      end else if (walking & advance) begin
        if (issue_last) begin
          walking <= 1'b0;
          read_addr <= '0;
          walk_bank <= '0;
        end else if (read_addr == ADDR_WIDTH'(BUFFER_DEPTH - 1)) begin
          read_addr <= '0;
          walk_bank <= walk_bank + 1'b1;
        end else begin
          read_addr <= read_addr + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read pipeline
  //////////////////////////////////////////////////

  assign side_in = '{bank: walk_bank, last: issue_last};

  // one stage, the storage read register
  latency_pipe #(
    .DEPTH(1),
    .payload_t(read_side_t)
  ) side_pipe_i (
    .capture_clk(capture_clk),
    .capture_reset(flush),
    .advance(advance),
    .in_valid(walking),
    .in_payload(side_in),
    .out_valid(side_valid),
    .out_payload(side_out)
  );

  // delayed bank picks the word out of the read registers
  assign read_bank = side_out.bank;
  assign beat_in = '{data: read_data, last: side_out.last};

  // retiming stages after the storage read
  latency_pipe #(
    .DEPTH(READ_LATENCY),
    .payload_t(stream_beat_t)
  ) beat_pipe_i (
    .capture_clk(capture_clk),
    .capture_reset(flush),
    .advance(advance),
    .in_valid(side_valid),
    .in_payload(beat_in),
    .out_valid(beat_valid),
    .out_payload(beat_out)
  );

  //////////////////////////////////////////////////
  // stream output register
  //////////////////////////////////////////////////

  // holds while valid and not ready
  always_ff @(posedge capture_clk) begin
    if (flush) begin
      readout_valid <= 1'b0;
    end else if (advance) begin
      readout_valid <= beat_valid;
    end
  end

  always_ff @(posedge capture_clk) begin
    if (advance) begin
      readout_out <= beat_out;
    end
  end

  assign readout_done = readout_valid & readout_ready & readout_out.last;

endmodule

// File: source/capture_buffer.sv
// multi-lane sample capture buffer with chained banks and a streamed readout
// single clock, the done pulse goes straight back to the write counter

`timescale 1ns/1ps
module capture_buffer import capture_pkg::*; #(
  parameter int BUFFER_DEPTH = 16,
  parameter int READ_LATENCY = 3
) (
  input logic capture_clk,
  input logic capture_reset,
  input capture_in_t capture_in,
  input lane_count_t active_channels,
  input logic start,
  input logic stop,
  input logic sw_reset,
  input logic readout_start,
  output logic full,
  output logic [LANES-1:0][$clog2(BUFFER_DEPTH+1)-1:0] write_depth,
  output stream_beat_t readout_out,
  output logic readout_valid,
  input logic readout_ready
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);

  capture_mode_t capture_mode;
  logic start_edge;
  logic active;
  logic group_full_now;
  logic readout_done;
  bank_mask_t write_enable;
  bank_mask_t write_mask;
  bank_mask_t bank_write;
  logic [LANES-1:0][ADDR_WIDTH-1:0] write_addr;
  logic [LANES-1:0][ADDR_WIDTH-1:0] bank_addr;
  lane_bus_t bank_data;
  bank_index_t read_bank;
  logic [ADDR_WIDTH-1:0] read_addr;
  logic read_enable;
  sample_t read_data;

  //////////////////////////////////////////////////
  // capture side
  //////////////////////////////////////////////////

  capture_control capture_control_i (
    .capture_clk(capture_clk),
    .capture_reset(capture_reset),
    .start(start),
    .stop(stop),
    .sw_reset(sw_reset),
    .group_full_now(group_full_now),
    .active_channels(active_channels),
    .capture_mode(capture_mode),
    .start_edge(start_edge),
    .active(active)
  );

  bank_write_counter #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) bank_write_counter_i (
    .capture_clk(capture_clk),
    .capture_reset(capture_reset),
    .sw_reset(sw_reset),
    .readout_done(readout_done),
    .capture_mode(capture_mode),
    .start_edge(start_edge),
    .write_enable(write_enable),
    .write_addr(write_addr),
    .write_mask(write_mask),
    .group_full_now(group_full_now),
    .full(full),
    .write_depth(write_depth)
  );

  bank_router #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) bank_router_i (
    .capture_clk(capture_clk),
    .capture_in(capture_in),
    .capture_mode(capture_mode),
    .active(active),
    .write_mask(write_mask),
    .write_addr(write_addr),
    .write_enable(write_enable),
    .bank_write(bank_write),
    .bank_addr(bank_addr),
    .bank_data(bank_data)
  );

  //////////////////////////////////////////////////
  // storage and readout
  //////////////////////////////////////////////////

  sample_banks #(
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) sample_banks_i (
    .capture_clk(capture_clk),
    .bank_write(bank_write),
    .bank_addr(bank_addr),
    .bank_data(bank_data),
    .read_bank(read_bank),
    .read_addr(read_addr),
    .read_enable(read_enable),
    .read_data(read_data)
  );

  readout_sequencer #(
    .BUFFER_DEPTH(BUFFER_DEPTH),
    .READ_LATENCY(READ_LATENCY)
  ) readout_sequencer_i (
    .capture_clk(capture_clk),
    .capture_reset(capture_reset),
    .sw_reset(sw_reset),
    .readout_start(readout_start),
    .read_bank(read_bank),
    .read_addr(read_addr),
    .read_enable(read_enable),
    .read_data(read_data),
    .readout_out(readout_out),
    .readout_valid(readout_valid),
    .readout_ready(readout_ready),
    .readout_done(readout_done)
  );

endmodule

// File: testbench/tb_clock_gen.sv
// free-running clock and synchronous reset for the capture buffer testbench
// reset is released 1 ns after the last reset edge, like every other input

`timescale 1ns/1ps
module tb_clock_gen #(
  parameter int PERIOD_NS = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic capture_clk,
  output logic capture_reset
);

  initial begin
    capture_clk = 1'b0;
    forever #(PERIOD_NS / 2) capture_clk = ~capture_clk;
  end

  // held high for a fixed number of rising edges
  initial begin
    capture_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge capture_clk);
    #1;
    capture_reset = 1'b0;
  end

endmodule

// File: testbench/capture_buffer_tb.sv
// capture buffer testbench with table-driven captures and a mirror of the banks
// every capture is followed by a full readout pass that is compared beat by beat

`timescale 1ns/1ps
module capture_buffer_tb import capture_pkg::*; ();

  localparam int BUFFER_DEPTH = 16;
  localparam int READ_LATENCY = 3;
  localparam int DEPTH_WIDTH = $clog2(BUFFER_DEPTH + 1);
  localparam int PASS_BEATS = LANES * BUFFER_DEPTH;
  localparam int PASS_TIMEOUT = 40 * PASS_BEATS;
  localparam int NUM_TESTS = 7;

  typedef logic [LANES-1:0][DEPTH_WIDTH-1:0] depth_array_t;
  typedef enum int {
    END_STOP,
    END_FULL,
    END_SW_RESET
  } end_kind_t;

  // one row of the test table
  typedef struct {
    string name;
    int lanes;
    int beats;
    end_kind_t how;
    bit gaps;
    bit lfsr_ready;
  } test_entry_t;

  logic capture_clk;
  logic capture_reset;
  capture_in_t capture_in;
  lane_count_t active_channels;
  logic start;
  logic stop;
  logic sw_reset;
  logic readout_start;
  logic full;
  depth_array_t write_depth;
  stream_beat_t readout_out;
  logic readout_valid;
  logic readout_ready;

  // mirror of the storage, pointers and write mask
  sample_t model_mem [LANES][BUFFER_DEPTH];
  int model_count [LANES];
  bank_mask_t model_mask;
  int model_lanes;
  bit model_active;

  logic [31:0] lfsr_state;
  int error_count;
  int test_errors;
  int failed_tests;
  int tests_run;
  string test_name;
  test_entry_t tests [NUM_TESTS];
  bit table_loaded;

  tb_clock_gen #(
    .PERIOD_NS(10),
    .RESET_CYCLES(8)
  ) clock_gen_i (
    .capture_clk(capture_clk),
    .capture_reset(capture_reset)
  );

  capture_buffer #(
    .BUFFER_DEPTH(BUFFER_DEPTH),
    .READ_LATENCY(READ_LATENCY)
  ) capture_buffer_i (
    .capture_clk(capture_clk),
    .capture_reset(capture_reset),
    .capture_in(capture_in),
    .active_channels(active_channels),
    .start(start),
    .stop(stop),
    .sw_reset(sw_reset),
    .readout_start(readout_start),
    .full(full),
    .write_depth(write_depth),
    .readout_out(readout_out),
    .readout_valid(readout_valid),
    .readout_ready(readout_ready)
  );

  //////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////

  // right-shifting Galois form with taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // one step per bit handed out
  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    return b;
  endfunction

  function automatic sample_t random_sample();
    sample_t v;
    for (int i = 0; i < SAMPLE_WIDTH; i++) begin
      v[i] = take_bit();
    end
    return v;
  endfunction

  function automatic lane_bus_t random_lanes();
    lane_bus_t v;
    for (int b = 0; b < LANES; b++) begin
      v[b] = random_sample();
    end
    return v;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // pointers are not cleared by a start, only the mask is loaded
  function automatic void model_start(input int lanes);
    model_lanes = lanes;
    model_active = 1'b1;
    for (int b = 0; b < LANES; b++) begin
      model_mask[b] = (b < lanes);
    end
  endfunction

  // bank b takes lane b mod lanes; a filled bank hands over to bank b + lanes
  function automatic void model_write(input lane_bus_t data);
    bank_mask_t mask_now;
    mask_now = model_mask;
    if (!model_active) begin
      return;
    end
    for (int b = 0; b < LANES; b++) begin
      if (mask_now[b]) begin
        model_mem[b][model_count[b]] = data[b % model_lanes];
        model_count[b]++;
        if (model_count[b] == BUFFER_DEPTH) begin
          model_mask[b] = 1'b0;
          if (b + model_lanes < LANES) begin
            model_mask[b + model_lanes] = 1'b1;
          end
        end
      end
    end
  endfunction

  function automatic void model_clear_pointers();
    for (int b = 0; b < LANES; b++) begin
      model_count[b] = 0;
    end
  endfunction

  function automatic depth_array_t expected_depths();
    depth_array_t d;
    for (int b = 0; b < LANES; b++) begin
      d[b] = DEPTH_WIDTH'(model_count[b]);
    end
    return d;
  endfunction

  // only the last group of banks counts
  function automatic logic expected_full();
    logic f;
    f = 1'b0;
    for (int b = LANES - model_lanes; b < LANES; b++) begin
      if (model_count[b] == BUFFER_DEPTH) begin
        f = 1'b1;
      end
    end
    return f;
  endfunction

  // bank-major and address-minor order with last on the final word
  function automatic stream_beat_t expected_beat(input int k);
    stream_beat_t e;
    e.data = model_mem[k / BUFFER_DEPTH][k % BUFFER_DEPTH];
    e.last = (k == PASS_BEATS - 1);
    return e;
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_beat(input string what, input stream_beat_t exp, input stream_beat_t act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected data %h last %b, actual data %h last %b",
               test_name, what, exp.data, exp.last, act.data, act.last);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_depth(input string what, input depth_array_t exp, input depth_array_t act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("error in %s: %s", test_name, msg);
    error_count++;
    test_errors++;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge capture_clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // capture and readout sequences
  //////////////////////////////////////////////////

  task automatic run_capture(input test_entry_t t);
    lane_bus_t data;
    active_channels = lane_count_t'(t.lanes);
    start = 1'b1;
    model_start(t.lanes);
    next_cycle();
    start = 1'b0;
    // capture goes active two edges after start
    repeat (4) next_cycle();
    for (int i = 0; i < t.beats; i++) begin
      // idle beats carry junk data that must not land anywhere
      while (t.gaps && take_bit()) begin
        capture_in.valid = 1'b0;
        capture_in.data = random_lanes();
        next_cycle();
      end
      data = random_lanes();
      capture_in.valid = 1'b1;
      capture_in.data = data;
      model_write(data);
      next_cycle();
    end
    capture_in.valid = 1'b0;
    repeat (4) next_cycle();
    check_depth("depths after capture", expected_depths(), write_depth);
    case (t.how)
      END_STOP: begin
        stop = 1'b1;
        model_active = 1'b0;
        next_cycle();
        stop = 1'b0;
      end
      END_SW_RESET: begin
        sw_reset = 1'b1;
        model_active = 1'b0;
        model_mask = '0;
        model_clear_pointers();
        next_cycle();
        sw_reset = 1'b0;
      end
      default: begin
        // the last group already filled and capture is over
        model_active = 1'b0;
      end
    endcase
    repeat (4) next_cycle();
    // beats after the end of capture are dropped
    repeat (3) begin
      data = random_lanes();
      capture_in.valid = 1'b1;
      capture_in.data = data;
      model_write(data);
      next_cycle();
    end
    capture_in.valid = 1'b0;
    repeat (4) next_cycle();
    check_depth("depths after end", expected_depths(), write_depth);
    check_flag("full after end", expected_full(), full);
  endtask

  task automatic run_readout(input bit lfsr_ready);
    stream_beat_t held_beat;
    bit holding;
    int got;
    int cycles;
    holding = 1'b0;
    got = 0;
    cycles = 0;
    next_cycle();
    readout_start = 1'b1;
    while (got < PASS_BEATS && cycles < PASS_TIMEOUT) begin
      readout_ready = lfsr_ready ? take_bit() : 1'b1;
      // a stalled beat must still be there and unchanged
      if (holding) begin
        check_flag("valid held under back-pressure", 1'b1, readout_valid);
        check_beat("beat held under back-pressure", held_beat, readout_out);
      end
      if (readout_valid && readout_ready) begin
        check_beat($sformatf("beat %0d", got), expected_beat(got), readout_out);
        got++;
        holding = 1'b0;
      end else if (readout_valid) begin
        holding = 1'b1;
        held_beat = readout_out;
      end else begin
        holding = 1'b0;
      end
      next_cycle();
      readout_start = 1'b0;
      cycles++;
    end
    readout_start = 1'b0;
    readout_ready = 1'b1;
    if (got < PASS_BEATS) begin
      note_failure($sformatf("readout pass ended after %0d of %0d beats", got, PASS_BEATS));
    end
    // the last transfer clears pointers and full latches
    model_clear_pointers();
    repeat (3) next_cycle();
    check_depth("depths after readout", expected_depths(), write_depth);
    check_flag("full after readout", 1'b0, full);
    check_flag("readout_valid after pass", 1'b0, readout_valid);
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, test_errors);
      failed_tests++;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    capture_in = '0;
    active_channels = lane_count_t'(1);
    start = 1'b0;
    stop = 1'b0;
    sw_reset = 1'b0;
    readout_start = 1'b0;
    readout_ready = 1'b1;
    lfsr_state = 32'hb5130891;
    error_count = 0;
    failed_tests = 0;
    tests_run = 0;
    model_mask = '0;
    model_lanes = 1;
    model_active = 1'b0;
    model_clear_pointers();
    for (int b = 0; b < LANES; b++) begin
      for (int a = 0; a < BUFFER_DEPTH; a++) begin
        model_mem[b][a] = '0;
      end
    end
    // first row fills every bank, so later passes never read unwritten words
    tests[0] = '{"one_lane_full", 1, 72, END_FULL, 1'b0, 1'b0};
    tests[1] = '{"four_lane_stop", 4, 10, END_STOP, 1'b0, 1'b0};
    tests[2] = '{"two_lane_gaps", 2, 40, END_FULL, 1'b1, 1'b0};
    tests[3] = '{"four_lane_backpressure", 4, 20, END_FULL, 1'b0, 1'b1};
    tests[4] = '{"one_lane_stop_backpressure", 1, 21, END_STOP, 1'b1, 1'b1};
    tests[5] = '{"two_lane_sw_reset", 2, 6, END_SW_RESET, 1'b0, 1'b0};
    // a start is only taken in idle, so this row needs the FSM back in idle
    tests[6] = '{"four_lane_after_sw_reset", 4, 5, END_STOP, 1'b0, 1'b0};
    table_loaded = 1'b1;

    @(negedge capture_reset);
    next_cycle();
    test_name = "reset_state";
    test_errors = 0;
    check_flag("readout_valid", 1'b0, readout_valid);
    check_flag("full", 1'b0, full);
    check_depth("depths", '0, write_depth);
    finish_test();

    for (int i = 0; i < NUM_TESTS; i++) begin
      test_name = tests[i].name;
      test_errors = 0;
      run_capture(tests[i]);
      run_readout(tests[i].lfsr_ready);
      finish_test();
    end

    $display("tests run %0d, failing tests %0d, check errors %0d",
             tests_run, failed_tests, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog sized from the table's beat counts
  initial begin
    int limit;
    wait (table_loaded);
    limit = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      limit += tests[i].beats;
    end
    limit = limit * (PASS_BEATS + 64);
    repeat (limit) @(posedge capture_clk);
    $display("timeout: run did not finish within %0d clock cycles", limit);
    $display("test failed");
    $finish;
  end

endmodule

// File: tb.f
source/capture_pkg.sv
source/latency_pipe.sv
source/capture_control.sv
source/bank_write_counter.sv
source/bank_router.sv
source/sample_banks.sv
source/readout_sequencer.sv
source/capture_buffer.sv
testbench/tb_clock_gen.sv
testbench/capture_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module capture_buffer_tb \
  -f tb.f -o capture_buffer_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/capture_buffer_sim > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && echo "simulation ok" \
  || { echo "simulation reported failure"; exit 1; }
